// File: hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int addr_width = 32;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        dirty_miss,
        replace,
        refill
    } cache_state_e;

    // one processor load or store
    typedef struct packed {
        logic                  write;
        logic                  uncached;
        logic [1:0]            size;
        logic [addr_width-1:0] addr;
        logic [3:0]            wstrb;
        logic [31:0]           wdata;
    } cpu_req_t;

    // burst high for a whole-line refill
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [1:0]            size;
        logic                  burst;
    } mem_rd_req_t;

    // line data travels beside this on its own port
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [3:0]            strb;
        logic [1:0]            size;
        logic                  burst;
    } mem_wr_req_t;

endpackage

`default_nettype wire

// File: hdl/cache_table.sv
`default_nettype none
`timescale 1ns/1ps

module cache_table #(
    parameter int num_way = 2,
    parameter int num_line = 64,
    parameter int bytes_per_line = 16,
    localparam int offset_width = $clog2(bytes_per_line),
    localparam int index_width = $clog2(num_line),
    localparam int tag_width = cache_pkg::addr_width - offset_width - index_width,
    localparam int words_per_line = bytes_per_line / 4,
    localparam int bank_width = $clog2(words_per_line),
    localparam int line_bits = bytes_per_line * 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [index_width-1:0] table_index,
    input  logic [tag_width-1:0]   table_tag,
    input  logic [bank_width-1:0]  table_bank,
    input  logic [num_way-1:0]     read_way,
    output logic [num_way-1:0]     hit_way,
    output logic [num_way-1:0]     valid_ways,
    output logic [31:0]            table_rdata,
    output logic [line_bits-1:0]   read_line,
    output logic [tag_width-1:0]   read_tag,
    input  logic                   data_we,
    input  logic [num_way-1:0]     data_way,
    input  logic [index_width-1:0] data_index,
    input  logic [bank_width-1:0]  data_bank,
    input  logic [31:0]            data_wdata,
    input  logic [3:0]             data_wstrb,
    input  logic [index_width-1:0] dirty_index,
    input  logic [num_way-1:0]     dirty_way,
    output logic                   dirty,
    input  logic [num_way-1:0]     dirty_wway,
    input  logic [index_width-1:0] dirty_windex,
    input  logic                   dirty_wdata,
    input  logic [num_way-1:0]     tag_wway,
    input  logic [index_width-1:0] tag_windex,
    input  logic [tag_width-1:0]   tag_wdata
);

    logic [tag_width-1:0] tag_mem [num_way][num_line];
    logic [num_line-1:0] valid_bits [num_way];
    logic [num_line-1:0] dirty_bits [num_way];
    logic [31:0] data_mem [num_way][num_line][words_per_line];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_way; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
        end else begin
            for (int w = 0; w < num_way; w++) begin
                if (tag_wway[w])
                    valid_bits[w][tag_windex] <= 1'b1;
                if (dirty_wway[w])
                    dirty_bits[w][dirty_windex] <= dirty_wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_way; w++) begin
            if (tag_wway[w])
                tag_mem[w][tag_windex] <= tag_wdata;
            // byte lanes of one bank
            for (int b = 0; b < 4; b++) begin
                if (data_we && data_way[w] && data_wstrb[b])
                    data_mem[w][data_index][data_bank][b*8 +: 8] <= data_wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        hit_way = '0;
        valid_ways = '0;
        table_rdata = '0;
        read_line = '0;
        read_tag = '0;
        dirty = 1'b0;
        for (int w = 0; w < num_way; w++) begin
            valid_ways[w] = valid_bits[w][table_index];
            hit_way[w] = valid_ways[w] && (tag_mem[w][table_index] == table_tag);
            if (hit_way[w])
                table_rdata |= data_mem[w][table_index][table_bank];
            // victim line for write-back
            if (read_way[w]) begin
                read_tag |= tag_mem[w][table_index];
                for (int k = 0; k < words_per_line; k++)
                    read_line[k*32 +: 32] |= data_mem[w][table_index][k];
            end
            if (dirty_way[w])
                dirty |= dirty_bits[w][dirty_index];
        end
    end

endmodule

`default_nettype wire

// File: hdl/replace_way_gen.sv
`default_nettype none
`timescale 1ns/1ps

module replace_way_gen #(
    parameter int num_way = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               advance,
    input  logic [num_way-1:0] valid_ways,
    output logic [num_way-1:0] victim_way
);

    localparam int way_bits = (num_way > 1) ? $clog2(num_way) : 1;

    logic [15:0] lfsr;
    logic found;

    // x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk) begin
        if (reset)
            lfsr <= 16'hace1;
        else if (advance)
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    end

    always_comb begin
        victim_way = '0;
        victim_way[lfsr[way_bits-1:0]] = 1'b1;
        found = 1'b0;
        // lowest invalid way wins
        for (int w = 0; w < num_way; w++) begin
            if (!valid_ways[w] && !found) begin
                victim_way = '0;
                victim_way[w] = 1'b1;
                found = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/cache.sv
`default_nettype none
`timescale 1ns/1ps

module cache #(
    parameter int num_way = 2,
    parameter int num_line = 64,
    parameter int bytes_per_line = 16,
    localparam int offset_width = $clog2(bytes_per_line),
    localparam int index_width = $clog2(num_line),
    localparam int tag_width = cache_pkg::addr_width - offset_width - index_width,
    localparam int words_per_line = bytes_per_line / 4,
    localparam int bank_width = $clog2(words_per_line),
    localparam int line_bits = bytes_per_line * 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid,
    input  cache_pkg::cpu_req_t    req,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [31:0]            rdata,
    output logic                   rd_req,
    output cache_pkg::mem_rd_req_t rd,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  logic [31:0]            ret_data,
    output logic                   wr_req,
    output cache_pkg::mem_wr_req_t wr,
    output logic [line_bits-1:0]   wr_data,
    input  logic                   wr_rdy,
    output logic [index_width-1:0] table_index,
    output logic [tag_width-1:0]   table_tag,
    output logic [bank_width-1:0]  table_bank,
    output logic [num_way-1:0]     read_way,
    output logic                   data_we,
    output logic [num_way-1:0]     data_way,
    output logic [index_width-1:0] data_index,
    output logic [bank_width-1:0]  data_bank,
    output logic [31:0]            data_wdata,
    output logic [3:0]             data_wstrb,
    output logic [index_width-1:0] dirty_index,
    output logic [num_way-1:0]     dirty_way,
    output logic [num_way-1:0]     dirty_wway,
    output logic [index_width-1:0] dirty_windex,
    output logic                   dirty_wdata,
    output logic [num_way-1:0]     tag_wway,
    output logic [index_width-1:0] tag_windex,
    output logic [tag_width-1:0]   tag_wdata,
    input  logic [num_way-1:0]     hit_way,
    input  logic                   dirty,
    input  logic [31:0]            table_rdata,
    input  logic [line_bits-1:0]   read_line,
    input  logic [tag_width-1:0]   read_tag,
    output logic                   advance,
    input  logic [num_way-1:0]     victim_way
);
    import cache_pkg::*;

    typedef struct packed {
        logic [num_way-1:0]     way;
        logic [index_width-1:0] index;
        logic [bank_width-1:0]  bank;
        logic [3:0]             wstrb;
        logic [31:0]            wdata;
    } wbuf_t;

    cache_state_e state;
    cache_state_e state_next;
    cpu_req_t req_buf;
    cpu_req_t repl_buf;
    logic [num_way-1:0] repl_way;
    wbuf_t wbuf;
    logic wbuf_busy;
    logic first_replace;
    logic [bank_width-1:0] refill_ptr;
    logic [tag_width-1:0] req_tag;
    logic [index_width-1:0] req_index;
    logic [bank_width-1:0] req_bank;
    logic [tag_width-1:0] repl_tag;
    logic [index_width-1:0] repl_index;
    logic [bank_width-1:0] repl_bank;
    logic hit;
    logic hit_write;
    logic overlap;
    logic victim_dirty;
    logic refill_done;
    logic fill_done;
    logic lookup_ok;
    logic fill_ok;
    logic [31:0] refill_word;

    assign req_tag = req_buf.addr[addr_width-1 -: tag_width];
    assign req_index = req_buf.addr[offset_width +: index_width];
    assign req_bank = req_buf.addr[2 +: bank_width];
    assign repl_tag = repl_buf.addr[addr_width-1 -: tag_width];
    assign repl_index = repl_buf.addr[offset_width +: index_width];
    assign repl_bank = repl_buf.addr[2 +: bank_width];

    assign hit = (state == lookup) && !req_buf.uncached && |hit_way;
    assign hit_write = hit && req_buf.write;
    // load to the bank the store is about to write waits a cycle
    assign overlap = hit_write && !req.write && (req.addr[2 +: bank_width] == req_bank);
    assign addr_ok = valid && (state == idle || hit) && !overlap;

    // victim line may be the one the write buffer is dirtying right now
    assign victim_dirty = dirty || (wbuf_busy && wbuf.index == req_index
                                    && |(wbuf.way & victim_way));

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // pending store lands on its own word only
            refill_word[i*8 +: 8] = (repl_buf.write && repl_buf.wstrb[i]
                                     && refill_ptr == repl_bank) ?
                                    repl_buf.wdata[i*8 +: 8] : ret_data[i*8 +: 8];
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle:
                if (addr_ok)
                    state_next = lookup;
            lookup:
                if (hit)
                    state_next = addr_ok ? lookup : idle;
                else if (req_buf.uncached)
                    state_next = req_buf.write ? dirty_miss : miss;
                else
                    state_next = victim_dirty ? dirty_miss : miss;
            miss:
                if (rd_rdy)
                    state_next = refill;
            dirty_miss:
                if (wr_rdy)
                    state_next = repl_buf.uncached ? idle : replace;
            replace:
                if (rd_req && rd_rdy)
                    state_next = refill;
            refill:
                if (ret_valid && ret_last)
                    state_next = idle;
            default:
                state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            wbuf_busy <= 1'b0;
            first_replace <= 1'b0;
            refill_ptr <= '0;
        end else begin
            state <= state_next;
            wbuf_busy <= hit_write;
            first_replace <= (state == dirty_miss) && wr_rdy && !repl_buf.uncached;
            if (state != refill)
                refill_ptr <= '0;
            else if (ret_valid)
                refill_ptr <= refill_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok)
            req_buf <= req;
        if (hit_write) begin
            wbuf.way <= hit_way;
            wbuf.index <= req_index;
            wbuf.bank <= req_bank;
            wbuf.wstrb <= req_buf.wstrb;
            wbuf.wdata <= req_buf.wdata;
        end
        if (state == lookup) begin
            repl_buf <= req_buf;
            repl_way <= victim_way;
        end
    end

    assign table_index = (state == lookup) ? req_index : repl_index;
    assign table_tag = req_tag;
    assign table_bank = req_bank;
    assign read_way = repl_way;
    assign dirty_index = req_index;
    assign dirty_way = victim_way;
    assign advance = (state == lookup) && !req_buf.uncached && !(|hit_way);

    assign refill_done = (state == refill) && ret_valid && ret_last;
    assign fill_done = refill_done && !repl_buf.uncached;

    // refill owns the data port; otherwise the write buffer drains
    always_comb begin
        if (state == refill) begin
            data_we = ret_valid && !repl_buf.uncached;
            data_way = repl_way;
            data_index = repl_index;
            data_bank = refill_ptr;
            data_wdata = refill_word;
            data_wstrb = 4'b1111;
        end else begin
            data_we = wbuf_busy;
            data_way = wbuf.way;
            data_index = wbuf.index;
            data_bank = wbuf.bank;
            data_wdata = wbuf.wdata;
            data_wstrb = wbuf.wstrb;
        end
    end

    assign dirty_wway = wbuf_busy ? wbuf.way : ({num_way{fill_done}} & repl_way);
    assign dirty_windex = wbuf_busy ? wbuf.index : repl_index;
    assign dirty_wdata = wbuf_busy || repl_buf.write;
    assign tag_wway = {num_way{fill_done}} & repl_way;
    assign tag_windex = repl_index;
    assign tag_wdata = repl_tag;

    assign lookup_ok = (state == lookup) && (hit || req_buf.write);
    assign fill_ok = (state == refill) && !repl_buf.uncached && !repl_buf.write
                     && ret_valid && refill_ptr == repl_bank;
    assign data_ok = lookup_ok || fill_ok || (refill_done && repl_buf.uncached);
    assign rdata = lookup_ok ? table_rdata : ret_data;

    // write-back pulse first and read request from the next cycle
    assign rd_req = (state == miss) || (state == replace && !first_replace);
    assign wr_req = repl_buf.uncached ? (state == dirty_miss) : first_replace;

    always_comb begin
        rd.addr = repl_buf.uncached ? repl_buf.addr :
                  {repl_tag, repl_index, {offset_width{1'b0}}};
        rd.size = repl_buf.uncached ? repl_buf.size : 2'd2;
        rd.burst = !repl_buf.uncached;
        wr.addr = repl_buf.uncached ? repl_buf.addr :
                  {read_tag, repl_index, {offset_width{1'b0}}};
        wr.strb = repl_buf.uncached ? repl_buf.wstrb : 4'b1111;
        wr.size = repl_buf.uncached ? repl_buf.size : 2'd2;
        wr.burst = !repl_buf.uncached;
        wr_data = repl_buf.uncached ? {{(line_bits-32){1'b0}}, repl_buf.wdata} : read_line;
    end

endmodule

`default_nettype wire

// File: hdl/cache_top.sv
`default_nettype none
`timescale 1ns/1ps

module cache_top #(
    parameter int num_way = 2,
    parameter int num_line = 64,
    parameter int bytes_per_line = 16,
    localparam int offset_width = $clog2(bytes_per_line),
    localparam int index_width = $clog2(num_line),
    localparam int tag_width = cache_pkg::addr_width - offset_width - index_width,
    localparam int bank_width = $clog2(bytes_per_line / 4),
    localparam int line_bits = bytes_per_line * 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid,
    input  cache_pkg::cpu_req_t    req,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [31:0]            rdata,
    output logic                   rd_req,
    output cache_pkg::mem_rd_req_t rd,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  logic [31:0]            ret_data,
    output logic                   wr_req,
    output cache_pkg::mem_wr_req_t wr,
    output logic [line_bits-1:0]   wr_data,
    input  logic                   wr_rdy
);

    // lookup and victim readout
    logic [index_width-1:0] table_index;
    logic [tag_width-1:0] table_tag;
    logic [bank_width-1:0] table_bank;
    logic [num_way-1:0] read_way;
    logic [num_way-1:0] hit_way;
    logic [num_way-1:0] valid_ways;
    logic [31:0] table_rdata;
    logic [line_bits-1:0] read_line;
    logic [tag_width-1:0] read_tag;
    // array write ports
    logic data_we;
    logic [num_way-1:0] data_way;
    logic [index_width-1:0] data_index;
    logic [bank_width-1:0] data_bank;
    logic [31:0] data_wdata;
    logic [3:0] data_wstrb;
    logic [index_width-1:0] dirty_index;
    logic [num_way-1:0] dirty_way;
    logic dirty;
    logic [num_way-1:0] dirty_wway;
    logic [index_width-1:0] dirty_windex;
    logic dirty_wdata;
    logic [num_way-1:0] tag_wway;
    logic [index_width-1:0] tag_windex;
    logic [tag_width-1:0] tag_wdata;
    // victim choice
    logic advance;
    logic [num_way-1:0] victim_way;

    cache #(
        .num_way(num_way),
        .num_line(num_line),
        .bytes_per_line(bytes_per_line)
    ) u_cache (.*);

    cache_table #(
        .num_way(num_way),
        .num_line(num_line),
        .bytes_per_line(bytes_per_line)
    ) u_table (.*);

    replace_way_gen #(
        .num_way(num_way)
    ) u_victim (.*);

endmodule

`default_nettype wire

// File: test/cache_sva.sv
`default_nettype none
`timescale 1ns/1ps

module cache_sva (
    input logic                   clk,
    input logic                   reset,
    input logic                   valid,
    input logic                   addr_ok,
    input logic                   data_ok,
    input logic                   rd_req,
    input cache_pkg::mem_rd_req_t rd,
    input logic                   rd_rdy,
    input logic                   wr_req
);

    int outstanding;
    int fail_count = 0;

    // accepted requests still waiting for data_ok
    always_ff @(posedge clk) begin
        if (reset)
            outstanding <= 0;
        else if (valid && addr_ok && !data_ok)
            outstanding <= outstanding + 1;
        else if (data_ok && !(valid && addr_ok))
            outstanding <= outstanding - 1;
    end

    rd_held: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd))
    else begin
        $error("rd_req dropped or rd changed before rd_rdy");
        fail_count++;
    end

    one_direction: assert property (@(posedge clk) disable iff (reset)
        !(rd_req && wr_req))
    else begin
        $error("rd_req and wr_req high together");
        fail_count++;
    end

    data_ok_owned: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> outstanding != 0)
    else begin
        $error("data_ok with no accepted request outstanding");
        fail_count++;
    end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !rd_req && !wr_req && !data_ok)
    else begin
        $error("memory request or data_ok in the first cycle after reset");
        fail_count++;
    end

endmodule

bind cache_top cache_sva u_sva (
    .clk(clk),
    .reset(reset),
    .valid(valid),
    .addr_ok(addr_ok),
    .data_ok(data_ok),
    .rd_req(rd_req),
    .rd(rd),
    .rd_rdy(rd_rdy),
    .wr_req(wr_req)
);

`default_nettype wire

// File: test/tb_cache.sv
`default_nettype none
`timescale 1ns/1ps

module tb_cache;
    import cache_pkg::*;

    localparam int mem_bytes = 4096;
    localparam int line_bytes = 16;
    localparam int max_wait = 400;

    typedef struct packed {
        logic        write;
        logic        hit_check;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] cycle;
    } pending_t;

    logic clk = 1'b0;
    logic reset;
    logic valid;
    cpu_req_t req;
    logic addr_ok;
    logic data_ok;
    logic [31:0] rdata;
    logic rd_req;
    mem_rd_req_t rd;
    logic rd_rdy = 1'b0;
    logic ret_valid = 1'b0;
    logic ret_last = 1'b0;
    logic [31:0] ret_data = '0;
    logic wr_req;
    mem_wr_req_t wr;
    logic [line_bytes*8-1:0] wr_data;
    logic wr_rdy = 1'b0;

    logic [7:0] mem [mem_bytes];
    logic [7:0] shadow [mem_bytes];
    pending_t pending [$];
    cpu_req_t last_req;
    logic check_hit;
    logic rd_busy = 1'b0;
    logic [31:0] rd_addr;
    int rd_count;
    int rd_words;
    int cycle_count = 0;
    int errors = 0;
    integer seed = 32'h3b8d;

    cache_top DUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] read_word(input logic from_shadow, input logic [31:0] addr);
        logic [31:0] word;
        logic [11:0] base;
        base = {addr[11:2], 2'b00};
        for (int b = 0; b < 4; b++)
            word[b*8 +: 8] = from_shadow ? shadow[base + b] : mem[base + b];
        return word;
    endfunction

    function automatic logic [line_bytes*8-1:0] shadow_line(input logic [31:0] addr);
        logic [line_bytes*8-1:0] line;
        logic [11:0] base;
        base = {addr[11:4], 4'h0};
        for (int b = 0; b < line_bytes; b++)
            line[b*8 +: 8] = shadow[base + b];
        return line;
    endfunction

    task automatic report_value(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
        errors++;
        $display("** Error %s: expected %0h, got %0h at %0t", name, expected, actual, $time);
    endtask

    task automatic send(input logic write, input logic uncached, input logic [31:0] addr,
                        input logic [3:0] wstrb, input logic [31:0] wdata, input logic hit);
        int waited;
        req.write = write;
        req.uncached = uncached;
        req.size = 2'd2;
        req.addr = addr;
        req.wstrb = write ? wstrb : 4'b0000;
        req.wdata = wdata;
        check_hit = hit;
        valid = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!addr_ok && waited < max_wait) begin
            waited++;
            @(negedge clk);
        end
        if (!addr_ok) begin
            errors++;
            $display("request to address %h was never accepted", addr);
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
    endtask

    task automatic load(input logic [31:0] addr, input logic hit);
        send(1'b0, 1'b0, addr, 4'b0000, 32'h0, hit);
    endtask

    // cached stores always answer in lookup
    task automatic store(input logic [31:0] addr, input logic [3:0] wstrb,
                         input logic [31:0] wdata);
        send(1'b1, 1'b0, addr, wstrb, wdata, 1'b1);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < max_wait) begin
            waited++;
            @(negedge clk);
        end
        if (pending.size() != 0) begin
            errors++;
            $display("%0d requests never got data_ok", pending.size());
        end
        @(posedge clk);
        #1;
    endtask

    // processor and memory side checks sampled mid-cycle
    always @(negedge clk) begin
        pending_t item;
        if (!reset) begin
            if (data_ok) begin
                assert (pending.size() != 0)
                else begin
                    errors++;
                    $display("data_ok raised with no request outstanding");
                end
                if (pending.size() != 0) begin
                    item = pending.pop_front();
                    if (!item.write) begin
                        assert (rdata == item.data)
                        else report_value("rdata", item.data, rdata);
                    end
                    if (item.hit_check) begin
                        assert (cycle_count == item.cycle + 1)
                        else begin
                            errors++;
                            $display("request to %h took %0d cycles to data_ok instead of one",
                                     item.addr, cycle_count - item.cycle);
                        end
                    end
                end
            end
            if (valid && addr_ok) begin
                item.write = req.write;
                item.hit_check = check_hit;
                item.addr = req.addr;
                item.data = read_word(1'b1, req.addr);
                item.cycle = cycle_count;
                for (int b = 0; b < 4; b++) begin
                    if (req.write && req.wstrb[b])
                        shadow[{req.addr[11:2], 2'b00} + b] = req.wdata[b*8 +: 8];
                end
                pending.push_back(item);
                last_req = req;
            end
            if (rd_req) begin
                assert (rd.burst == !last_req.uncached)
                else report_value("rd.burst", !last_req.uncached, rd.burst);
                if (rd.burst) begin
                    assert (rd.addr == {last_req.addr[31:4], 4'h0})
                    else report_value("rd.addr", {last_req.addr[31:4], 4'h0}, rd.addr);
                end else begin
                    assert (rd.addr == last_req.addr)
                    else report_value("rd.addr", last_req.addr, rd.addr);
                    assert (rd.size == last_req.size)
                    else report_value("rd.size", last_req.size, rd.size);
                end
            end
            if (wr_req) begin
                assert (wr.burst == !last_req.uncached)
                else report_value("wr.burst", !last_req.uncached, wr.burst);
            end
            if (wr_req && wr.burst) begin
                assert (wr.addr[3:0] == 4'h0)
                else report_value("wr.addr", {wr.addr[31:4], 4'h0}, wr.addr);
                assert (wr_data == shadow_line(wr.addr))
                else report_value("wr_data", shadow_line(wr.addr), wr_data);
            end
            if (wr_req && !wr.burst) begin
                assert (wr.addr == last_req.addr)
                else report_value("wr.addr", last_req.addr, wr.addr);
                assert (wr.strb == last_req.wstrb)
                else report_value("wr.strb", last_req.wstrb, wr.strb);
                assert (wr.size == last_req.size)
                else report_value("wr.size", last_req.size, wr.size);
                assert (wr_data[31:0] == last_req.wdata)
                else report_value("wr_data", last_req.wdata, wr_data[31:0]);
            end
        end
    end

    // memory model handshakes as the DUT will see them at the next edge
    always @(negedge clk) begin
        logic [11:0] base;
        if (reset) begin
            rd_busy = 1'b0;
        end else begin
            if (ret_valid) begin
                rd_count++;
                if (ret_last)
                    rd_busy = 1'b0;
            end
            if (rd_req && rd_rdy) begin
                rd_busy = 1'b1;
                rd_addr = rd.burst ? {rd.addr[31:4], 4'h0} : {rd.addr[31:2], 2'b00};
                rd_words = rd.burst ? line_bytes / 4 : 1;
                rd_count = 0;
            end
            // write-back pulse needs no wr_rdy of its own
            if (wr_req && (wr.burst || wr_rdy)) begin
                base = wr.burst ? {wr.addr[11:4], 4'h0} : {wr.addr[11:2], 2'b00};
                for (int b = 0; b < line_bytes; b++) begin
                    if (wr.burst || (b < 4 && wr.strb[b]))
                        mem[base + b] = wr_data[b*8 +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (reset) begin
            rd_rdy = 1'b0;
            wr_rdy = 1'b0;
            ret_valid = 1'b0;
            ret_last = 1'b0;
        end else begin
            rd_rdy = ($random(seed) & 3) != 0;
            wr_rdy = ($random(seed) & 3) != 0;
            if (rd_busy && ($random(seed) & 3) != 0) begin
                ret_valid = 1'b1;
                ret_data = read_word(1'b0, rd_addr + rd_count * 4);
                ret_last = (rd_count == rd_words - 1);
            end else begin
                ret_valid = 1'b0;
                ret_last = 1'b0;
            end
        end
    end

    initial begin
        valid = 1'b0;
        req = '0;
        check_hit = 1'b0;
        reset = 1'b1;
        // low byte xor 5a folded with the upper address bits
        for (int i = 0; i < mem_bytes; i++) begin
            mem[i] = i[7:0] ^ {4'h0, i[11:8]} ^ 8'h5a;
            shadow[i] = mem[i];
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // cold misses then hits on the filled lines
        for (int i = 0; i < 8; i++)
            load(32'h100 + i * 4, i % 4 != 0);
        for (int i = 0; i < 8; i++)
            load(32'h100 + i * 4, 1'b1);
        load(32'h010, 1'b0);
        load(32'h014, 1'b1);
        drain();

        // store hit followed by loads of the same word and a neighbour
        store(32'h104, 4'b0101, 32'ha1b2c3d4);
        load(32'h104, 1'b1);
        store(32'h108, 4'b1111, 32'h0badf00d);
        load(32'h10c, 1'b1);
        load(32'h108, 1'b1);
        drain();

        // three tags on index 0x20
        for (int r = 0; r < 3; r++) begin
            for (int t = 0; t < 3; t++)
                store(32'h200 + t * 32'h400 + r * 4, 4'b1111, 32'hc0de0000 | (r << 4) | t);
        end
        for (int t = 0; t < 3; t++) begin
            for (int w = 0; w < 4; w++)
                load(32'h200 + t * 32'h400 + w * 4, 1'b0);
        end
        drain();

        // uncached region is never cached
        send(1'b0, 1'b1, 32'hc24, 4'b0000, 32'h0, 1'b0);
        send(1'b1, 1'b1, 32'hc24, 4'b0011, 32'h7e571234, 1'b1);
        send(1'b0, 1'b1, 32'hc24, 4'b0000, 32'h0, 1'b0);
        send(1'b1, 1'b1, 32'hc36, 4'b1100, 32'h55aa0000, 1'b1);
        send(1'b0, 1'b1, 32'hc36, 4'b0000, 32'h0, 1'b0);
        drain();

        repeat (4) @(posedge clk);
        $display("errors: %0d in testbench checks, %0d in protocol assertions",
                 errors, DUT.u_sva.fail_count);
        if (errors == 0 && DUT.u_sva.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
hdl/cache_pkg.sv
hdl/cache_table.sv
hdl/replace_way_gen.sv
hdl/cache.sv
hdl/cache_top.sv
test/cache_sva.sv
test/tb_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_cache
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUNFLAGS ?= +verilator+error+limit+1000
PASS_MSG ?= TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS RUNFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
